//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_zx_audio -f src.f \
   -o sim_zx_audio > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/sim_zx_audio > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1

//--- src.f
+incdir+tests
verilog/zx_audio_pkg.sv
verilog/ay_tone_psg.sv
verilog/audio_mixer.sv
verilog/io_port_regs.sv
verilog/turbosound.sv
verilog/zx_audio_top.sv
tests/tb_zx_audio.sv

//--- tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: kind, port, write data, expected value
// Window rows expect a ones count, random reads carry the AY mask
task automatic load_vectors();
   ////////////////////////////////
   // State after reset
   ////////////////////////////////
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(0, 0, 0, 0, 0, 0, 0));
   add_row(K_RD,  ZX_ADDR,  8'h00, 'h00);
   // All sixteen registers of chip 1, then chip 2
   for (int chip = 0; chip < 2; chip++) begin
      add_row(K_WR, AY_ADDR, (chip == 0) ? 8'hFF : 8'hFE, 0);
      for (int r = 0; r < 16; r++) begin
         add_row(K_WR, AY_ADDR, 8'(r), 0);
         add_row(K_RD, AY_ADDR, 8'h00, 'h00);
      end
   end
   add_row(K_WR,  AY_ADDR,  8'hFF, 0);
   add_row(K_WR,  ZX_ADDR,  8'hF7, 0);
   add_row(K_RD,  ZX_ADDR,  8'h00, 'hF7);
   add_row(K_RD,  ZX_DATA,  8'h00, 'h00);

   ////////////////////////////////
   // ZX-Uno registers
   ////////////////////////////////
   add_row(K_WRR, ZX_DATA,  8'h00, 0);
   add_row(K_RDR, ZX_DATA,  8'h00, 'h07);
   add_row(K_WR,  ZX_ADDR,  8'h05, 0);
   add_row(K_RD,  ZX_ADDR,  8'h00, 'h05);
   // Unmapped register, idle bus
   add_row(K_NONE, ZX_DATA, 8'h00, 'hFF);
   add_row(K_WR,  ZX_ADDR,  8'hF7, 0);
   add_row(K_WR,  ZX_DATA,  8'h00, 0);
   add_row(K_RD,  ZX_DATA,  8'h00, 'h00);

   ////////////////////////////////
   // AY readback, both chips
   ////////////////////////////////
   add_row(K_WR,  AY_ADDR,  8'hFF, 0);
   add_row(K_WR,  AY_ADDR,  8'h01, 0);
   add_row(K_WR,  AY_DATA,  8'hA5, 0);
   add_row(K_RD,  AY_ADDR,  8'h00, 'h05);
   add_row(K_WR,  AY_ADDR,  8'h08, 0);
   add_row(K_WRR, AY_DATA,  8'h00, 0);
   add_row(K_RDR, AY_ADDR,  8'h00, 'h1F);
   // Chip 2 coarse periods
   add_row(K_WR,  AY_ADDR,  8'hFE, 0);
   add_row(K_WR,  AY_ADDR,  8'h01, 0);
   add_row(K_WRR, AY_DATA,  8'h00, 0);
   add_row(K_RDR, AY_ADDR,  8'h00, 'h0F);
   add_row(K_WR,  AY_ADDR,  8'h03, 0);
   add_row(K_WRR, AY_DATA,  8'h00, 0);
   add_row(K_RDR, AY_ADDR,  8'h00, 'h0F);
   // Chip 1 untouched by chip 2 writes
   add_row(K_WR,  AY_ADDR,  8'hFF, 0);
   add_row(K_WR,  AY_ADDR,  8'h01, 0);
   add_row(K_RD,  AY_ADDR,  8'h00, 'h05);
   add_row(K_WR,  AY_ADDR,  8'h08, 0);
   add_row(K_WR,  AY_DATA,  8'h00, 0);

   ////////////////////////////////
   // ULA port and beeper
   ////////////////////////////////
   add_row(K_EAR, 16'h0000, 8'h00, 0);
   add_row(K_RD,  ULA_PORT, 8'h00, 'hBF);
   add_row(K_EAR, 16'h0000, 8'h01, 0);
   add_row(K_RD,  ULA_PORT, 8'h00, 'hFF);
   add_row(K_WR,  ULA_PORT, 8'h10, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(0, 0, 0, 0, 1, 0, 1));
   add_row(K_EAR, 16'h0000, 8'h00, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(0, 0, 0, 0, 1, 0, 0));
   add_row(K_WR,  ULA_PORT, 8'h08, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(0, 0, 0, 0, 0, 1, 0));
   add_row(K_WR,  ULA_PORT, 8'h00, 0);

   ////////////////////////////////
   // Fixed levels, gain and mute
   ////////////////////////////////
   add_row(K_WR,  AY_ADDR,  8'h07, 0);
   add_row(K_WR,  AY_DATA,  8'h3F, 0);
   add_row(K_WR,  AY_ADDR,  8'h08, 0);
   add_row(K_WR,  AY_DATA,  8'h0F, 0);
   add_row(K_WR,  AY_ADDR,  8'h09, 0);
   add_row(K_WR,  AY_DATA,  8'h07, 0);
   add_row(K_WR,  AY_ADDR,  8'hFE, 0);
   add_row(K_WR,  AY_ADDR,  8'h07, 0);
   add_row(K_WR,  AY_DATA,  8'hFF, 0);
   add_row(K_WR,  AY_ADDR,  8'h0A, 0);
   add_row(K_WR,  AY_DATA,  8'h0B, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(22, 11, 0, 0, 0, 0, 0));
   add_row(K_WR,  ZX_DATA,  8'h02, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(22, 11, 2, 0, 0, 0, 0));
   add_row(K_WR,  ZX_DATA,  8'h07, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(22, 11, 3, 1, 0, 0, 0));
   add_row(K_WR,  ZX_DATA,  8'h03, 0);
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(22, 11, 3, 0, 0, 0, 0));

   ////////////////////////////////
   // Square wave on chip 1 tone A
   ////////////////////////////////
   add_row(K_WR,  AY_ADDR,  8'hFF, 0);
   add_row(K_WR,  AY_ADDR,  8'h00, 0);
   add_row(K_WR,  AY_DATA,  8'h04, 0);
   add_row(K_WR,  AY_ADDR,  8'h01, 0);
   add_row(K_WR,  AY_DATA,  8'h00, 0);
   add_row(K_WR,  AY_ADDR,  8'h09, 0);
   add_row(K_WR,  AY_DATA,  8'h00, 0);
   add_row(K_WR,  AY_ADDR,  8'h07, 0);
   add_row(K_WR,  AY_DATA,  8'h3E, 0);
   add_row(K_WR,  ZX_DATA,  8'h07, 0);
   // High for half of each 64 cycle wave
   add_row(K_WIN, 16'h0000, 8'h00, mix_count(15, 0, 3, 1, 0, 0, 0) / 2);
endtask

`endif

//--- tests/tb_zx_audio.sv
`timescale 1ns/1ps

module tb_zx_audio;

   localparam int PSG_DIV    = 8;
   localparam int DAC_BITS   = 10;
   localparam int BEEP_LEVEL = 256;
   localparam int WINDOW     = 1 << DAC_BITS;

   // CPU side port numbers
   localparam logic [15:0] ZX_ADDR  = 16'hFC3B;
   localparam logic [15:0] ZX_DATA  = 16'hFD3B;
   localparam logic [15:0] AY_ADDR  = 16'hFFFD;
   localparam logic [15:0] AY_DATA  = 16'hBFFD;
   localparam logic [15:0] ULA_PORT = 16'h00FE;

   localparam zx_audio_pkg::io_req_t IDLE_BUS =
      '{addr: 16'h0000, wdata: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};

   // Row kinds, random ones use the last $urandom byte
   typedef enum logic [2:0] {K_WR, K_RD, K_NONE, K_WRR, K_RDR, K_EAR, K_WIN} kind_e;

   typedef struct packed {
      kind_e       kind;
      logic [15:0] port;
      logic [7:0]  data;
      logic [15:0] exp_val;
   } vec_t;

   logic                  clk;
   logic                  rst_n;
   zx_audio_pkg::io_req_t io;
   logic                  ear;
   logic [7:0]            rdata;
   logic                  bus_oe_n;
   logic                  audio_out;

   vec_t       vectors[$];
   logic [7:0] rand_q;
   int         cycle_cnt   = 0;
   int         cycle_limit = 0;

   zx_audio_top #(
      .PSG_DIV    (PSG_DIV),
      .DAC_BITS   (DAC_BITS),
      .BEEP_LEVEL (BEEP_LEVEL)
   ) dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .io        (io),
      .ear       (ear),
      .rdata     (rdata),
      .bus_oe_n  (bus_oe_n),
      .audio_out (audio_out)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////
   // Helpers
   ////////////////////////////////

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   // Mix level rule, saturated at full scale
   function automatic int mix_count(input int ay1, input int ay2, input int gain,
                                    input int mute, input int spk, input int mic,
                                    input int ear_lvl);
      int lvl;
      lvl = (ay1 + (mute != 0 ? 0 : ay2)) << gain;
      lvl = lvl + (spk != 0 ? BEEP_LEVEL : 0);
      lvl = lvl + (mic != 0 ? 64 : 0);
      lvl = lvl + (ear_lvl != 0 ? 32 : 0);
      if (lvl > WINDOW - 1) begin
         lvl = WINDOW - 1;
      end
      return lvl;
   endfunction

   function automatic int row_cycles(input kind_e kind);
      int n;
      case (kind)
         K_WIN:   n = 2 * WINDOW;
         K_EAR:   n = 1;
         default: n = 3;
      endcase
      return n;
   endfunction

   task automatic add_row(input kind_e kind, input logic [15:0] port,
                          input logic [7:0] data, input int exp_val);
      vectors.push_back('{kind: kind, port: port, data: data, exp_val: 16'(exp_val)});
   endtask

   `include "tb_vectors.svh"

   // Two active cycles, then one idle
   task automatic bus_access(input logic [15:0] port, input logic [7:0] wval,
                             input logic is_rd, output logic [7:0] rd_val,
                             output logic oe_val);
      @(posedge clk);
      io <= '{addr: port, wdata: wval, iorq_n: 1'b0, rd_n: !is_rd, wr_n: is_rd};
      @(posedge clk);
      // Second cycle, sampled mid period
      @(negedge clk);
      rd_val = rdata;
      oe_val = bus_oe_n;
      @(posedge clk);
      io <= IDLE_BUS;
   endtask

   task automatic check_read(input int row, input logic [15:0] port,
                             input logic [7:0] exp_rd);
      logic [7:0] rd_val;
      logic       oe_val;
      bus_access(port, 8'h00, 1'b1, rd_val, oe_val);
      assert (oe_val == 1'b0) else
         report_error($sformatf("Mismatch bus_oe_n row %0d port 0x%04h: got 0x%0h expected 0x0",
                                row, port, oe_val));
      assert (rd_val == exp_rd) else
         report_error($sformatf("Mismatch rdata row %0d port 0x%04h: got 0x%02h expected 0x%02h",
                                row, port, rd_val, exp_rd));
   endtask

   task automatic check_no_reply(input int row, input logic [15:0] port);
      logic [7:0] rd_val;
      logic       oe_val;
      bus_access(port, 8'h00, 1'b1, rd_val, oe_val);
      assert (oe_val == 1'b1) else
         report_error($sformatf("Mismatch bus_oe_n row %0d port 0x%04h: got 0x%0h expected 0x1",
                                row, port, oe_val));
      assert (rd_val == 8'hFF) else
         report_error($sformatf("Mismatch rdata row %0d port 0x%04h: got 0x%02h expected 0xff",
                                row, port, rd_val));
   endtask

   // Settle, then count ones over one window
   task automatic check_window(input int row, input int exp_ones);
      int ones;
      int slack;
      ones = 0;
      repeat (WINDOW) @(posedge clk);
      repeat (WINDOW) begin
         @(negedge clk);
         if (audio_out) begin
            ones++;
         end
      end
      // Silence has to be exact
      slack = (exp_ones == 0) ? 0 : 2;
      assert (ones >= exp_ones - slack && ones <= exp_ones + slack) else
         report_error($sformatf("Mismatch audio_out count row %0d: got 0x%0h expected 0x%0h",
                                row, ones, exp_ones));
   endtask

   ////////////////////////////////
   // Timeout
   ////////////////////////////////

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_limit == 0 || cycle_cnt < cycle_limit) else
         report_error("Timeout, the table did not finish within its cycle budget");
   end

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////

   initial begin
      logic [7:0] rd_val;
      logic       oe_val;
      int         total;
      rst_n  = 1'b0;
      io     = IDLE_BUS;
      ear    = 1'b0;
      rand_q = 8'h00;
      void'($urandom(75));
      load_vectors();
      // Reset plus every row, with 10% slack
      total = 8;
      foreach (vectors[i]) begin
         total += row_cycles(vectors[i].kind);
      end
      cycle_limit = total + total / 10;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      foreach (vectors[i]) begin
         case (vectors[i].kind)
            K_WR: begin
               bus_access(vectors[i].port, vectors[i].data, 1'b0, rd_val, oe_val);
            end
            K_WRR: begin
               rand_q = 8'($urandom);
               bus_access(vectors[i].port, rand_q, 1'b0, rd_val, oe_val);
            end
            K_RD: begin
               check_read(i, vectors[i].port, vectors[i].exp_val[7:0]);
            end
            // Expected column holds the register mask
            K_RDR: begin
               check_read(i, vectors[i].port, rand_q & vectors[i].exp_val[7:0]);
            end
            K_NONE: begin
               check_no_reply(i, vectors[i].port);
            end
            K_EAR: begin
               @(posedge clk);
               ear <= vectors[i].data[0];
            end
            default: begin
               check_window(i, int'(vectors[i].exp_val));
            end
         endcase
      end
      $display("Verification passed");
      $finish;
   end

endmodule

//--- verilog/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer #(
   parameter int DAC_BITS   = 10,
   parameter int BEEP_LEVEL = 256
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  zx_audio_pkg::psg_level_t ay1_level,
   input  zx_audio_pkg::psg_level_t ay2_level,
   input  logic [1:0]               ay_gain,
   input  logic                     ay2_mute,
   input  zx_audio_pkg::beeper_t    beep,
   output logic                     audio_out
);

   // Room for the AY sum shifted by 3 plus all fixed weights
   localparam int SUM_W     = (DAC_BITS > 10 ? DAC_BITS : 10) + 2;
   localparam int MAX_LEVEL = (1 << DAC_BITS) - 1;

   logic [6:0]          ay_sum;
   logic [SUM_W-1:0]    ay_scaled;
   logic [SUM_W-1:0]    mix_sum;
   logic [DAC_BITS-1:0] mix_level;
   logic [DAC_BITS-1:0] acc_q;
   logic [DAC_BITS:0]   acc_next;

   ////////////////////////////////
   // Mix
   ////////////////////////////////

   assign ay_sum    = 7'(ay1_level) + (ay2_mute ? 7'd0 : 7'(ay2_level));
   assign ay_scaled = SUM_W'(ay_sum) << ay_gain;

   always_comb begin
      mix_sum = ay_scaled;
      if (beep.spk) begin
         mix_sum = mix_sum + SUM_W'(BEEP_LEVEL);
      end
      if (beep.mic) begin
         mix_sum = mix_sum + SUM_W'(64);
      end
      if (beep.ear) begin
         mix_sum = mix_sum + SUM_W'(32);
      end
      // Clip to full scale
      if (mix_sum > SUM_W'(MAX_LEVEL)) begin
         mix_level = DAC_BITS'(MAX_LEVEL);
      end else begin
         mix_level = mix_sum[DAC_BITS-1:0];
      end
   end

   ////////////////////////////////
   // First-order delta-sigma
   ////////////////////////////////

   // Carry out is the one-bit stream
   assign acc_next = {1'b0, acc_q} + {1'b0, mix_level};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_q     <= '0;
         audio_out <= 1'b0;
      end else begin
         acc_q     <= acc_next[DAC_BITS-1:0];
         audio_out <= acc_next[DAC_BITS];
      end
   end

   a_wrap_sets_carry : assert property (@(posedge clk) disable iff (!rst_n)
      (acc_q < $past(acc_q)) |-> audio_out);

endmodule

//--- verilog/ay_tone_psg.sv
`timescale 1ns/1ps

module ay_tone_psg (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     tick,
   input  logic                     addr_we,
   input  logic                     data_we,
   input  logic [7:0]               wdata,
   output logic [7:0]               rdata,
   output zx_audio_pkg::psg_level_t level
);

   logic [7:0]  regs [16];
   logic [3:0]  reg_addr;
   logic [11:0] tone_cnt [3];
   logic [11:0] period [3];
   logic [2:0]  tone_q;
   logic [2:0]  chan_high;

   // Bits the real chip keeps per register
   function automatic logic [7:0] reg_mask(input logic [3:0] idx);
      logic [7:0] m;
      case (idx)
         4'd1, 4'd3, 4'd5, 4'd13: m = 8'h0F;
         4'd6, 4'd8, 4'd9, 4'd10: m = 8'h1F;
         default:                 m = 8'hFF;
      endcase
      return m;
   endfunction

   ////////////////////////////////
   // Register file
   ////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_addr <= '0;
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else begin
         // Only the low nibble selects a register
         if (addr_we) begin
            reg_addr <= wdata[3:0];
         end
         if (data_we) begin
            regs[reg_addr] <= wdata;
         end
      end
   end

   assign rdata = regs[reg_addr] & reg_mask(reg_addr);

   ////////////////////////////////
   // Tone generators
   ////////////////////////////////

   // 12-bit period from fine and coarse registers
   always_comb begin
      for (int n = 0; n < 3; n++) begin
         period[n] = {regs[2*n+1][3:0], regs[2*n]};
         // Zero behaves as one
         if (period[n] == 12'd0) begin
            period[n] = 12'd1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tone_q <= '1;
         for (int n = 0; n < 3; n++) begin
            tone_cnt[n] <= '0;
         end
      end else if (tick) begin
         for (int n = 0; n < 3; n++) begin
            // Greater-or-equal covers a period shortened mid count
            if (tone_cnt[n] >= period[n] - 12'd1) begin
               tone_cnt[n] <= '0;
               tone_q[n]   <= ~tone_q[n];
            end else begin
               tone_cnt[n] <= tone_cnt[n] + 12'd1;
            end
         end
      end
   end

   ////////////////////////////////
   // Output level
   ////////////////////////////////

   // Disabled tone reads as a steady high
   assign chan_high = tone_q | regs[7][2:0];

   always_comb begin
      level = '0;
      for (int n = 0; n < 3; n++) begin
         if (chan_high[n]) begin
            level = level + 6'(regs[8+n][3:0]);
         end
      end
   end

endmodule

//--- verilog/io_port_regs.sv
`timescale 1ns/1ps

module io_port_regs (
   input  logic                  clk,
   input  logic                  rst_n,
   input  zx_audio_pkg::io_req_t io,
   input  logic                  ear,
   output zx_audio_pkg::io_rsp_t rsp,
   output logic [7:0]            zxuno_addr,
   output logic [1:0]            ay_gain,
   output logic                  ay2_mute,
   output zx_audio_pkg::beeper_t beep
);

   logic       wr_n_q;
   logic       wr_stb;
   logic       rd_acc;
   logic       addr_port;
   logic       data_port;
   logic       ula_port;
   logic       regwr;
   logic       regrd;
   logic [2:0] audio_ctrl;
   logic       spk_q;
   logic       mic_q;

   ////////////////////////////////
   // Port decode
   ////////////////////////////////

   assign addr_port = (io.addr == zx_audio_pkg::ZXUNO_ADDR_PORT);
   assign data_port = (io.addr == zx_audio_pkg::ZXUNO_DATA_PORT);
   // ULA answers on any even port with low byte 0xFE
   assign ula_port  = (io.addr[7:0] == zx_audio_pkg::ULA_PORT_LSB);

   // Previous wr_n, one write per access
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_n_q <= 1'b1;
      end else begin
         wr_n_q <= io.wr_n;
      end
   end

   assign wr_stb = !io.iorq_n && !io.wr_n && wr_n_q;
   assign rd_acc = !io.iorq_n && !io.rd_n;

   // ZX-Uno register strobes
   assign regwr = wr_stb && data_port;
   assign regrd = rd_acc && data_port;

   ////////////////////////////////
   // Registers
   ////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         zxuno_addr <= '0;
         audio_ctrl <= '0;
         spk_q      <= 1'b0;
         mic_q      <= 1'b0;
      end else begin
         if (wr_stb && addr_port) begin
            zxuno_addr <= io.wdata;
         end
         if (regwr && zxuno_addr == zx_audio_pkg::REG_AUDIO_CTRL) begin
            audio_ctrl <= io.wdata[2:0];
         end
         // Beeper bit 4, mic bit 3
         if (wr_stb && ula_port) begin
            spk_q <= io.wdata[4];
            mic_q <= io.wdata[3];
         end
      end
   end

   assign ay_gain  = audio_ctrl[1:0];
   assign ay2_mute = audio_ctrl[2];
   assign beep     = '{spk: spk_q, mic: mic_q, ear: ear};

   // Combinational read side
   always_comb begin
      rsp = '{rdata: 8'hFF, oe_n: 1'b1};
      if (rd_acc && addr_port) begin
         rsp = '{rdata: zxuno_addr, oe_n: 1'b0};
      end else if (regrd && zxuno_addr == zx_audio_pkg::REG_AUDIO_CTRL) begin
         rsp = '{rdata: {5'b0, audio_ctrl}, oe_n: 1'b0};
      end else if (rd_acc && ula_port) begin
         // Ear level lands in bit 6
         rsp = '{rdata: {1'b1, ear, 6'b11_1111}, oe_n: 1'b0};
      end
   end

   // Reply only inside a read cycle
   a_oe_only_on_read : assert property (@(posedge clk) disable iff (!rst_n)
      !rsp.oe_n |-> !io.rd_n);

endmodule

//--- verilog/turbosound.sv
`timescale 1ns/1ps

module turbosound #(
   parameter int PSG_DIV = 8
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  zx_audio_pkg::io_req_t    io,
   output zx_audio_pkg::io_rsp_t    rsp,
   output zx_audio_pkg::psg_level_t ay1_level,
   output zx_audio_pkg::psg_level_t ay2_level
);

   localparam int DIV_W = $clog2(PSG_DIV + 1);

   logic [DIV_W-1:0] div_cnt;
   logic             tick;
   logic             wr_n_q;
   logic             wr_stb;
   logic             rd_acc;
   logic             ay_addr_port;
   logic             ay_data_port;
   logic             sel_ay2;
   logic             sel_code;
   logic [1:0]       addr_we;
   logic [1:0]       data_we;
   logic [7:0]       ay1_rdata;
   logic [7:0]       ay2_rdata;

   ////////////////////////////////
   // Tone tick
   ////////////////////////////////

   // Shared by both chips so they stay in phase
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else if (tick) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign tick = (div_cnt == DIV_W'(PSG_DIV - 1));

   ////////////////////////////////
   // AY port decode
   ////////////////////////////////

   // BC1 side, address latch and read
   assign ay_addr_port = io.addr[15] && io.addr[14] && io.addr[1:0] == 2'b01;
   // BDIR side, data write
   assign ay_data_port = io.addr[15] && !io.addr[14] && io.addr[1:0] == 2'b01;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_n_q <= 1'b1;
      end else begin
         wr_n_q <= io.wr_n;
      end
   end

   assign wr_stb = !io.iorq_n && !io.wr_n && wr_n_q;
   assign rd_acc = !io.iorq_n && !io.rd_n;

   assign sel_code = (io.wdata == zx_audio_pkg::AY_SEL_1) ||
                     (io.wdata == zx_audio_pkg::AY_SEL_2);

   // Chip 1 after reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sel_ay2 <= 1'b0;
      end else if (wr_stb && ay_addr_port && sel_code) begin
         sel_ay2 <= (io.wdata == zx_audio_pkg::AY_SEL_2);
      end
   end

   // Strobes to the selected chip only, bit 1 is chip 2
   always_comb begin
      addr_we = '0;
      data_we = '0;
      if (wr_stb && ay_addr_port && !sel_code) begin
         addr_we[sel_ay2] = 1'b1;
      end
      if (wr_stb && ay_data_port) begin
         data_we[sel_ay2] = 1'b1;
      end
   end

   assign rsp.oe_n  = !(rd_acc && ay_addr_port);
   assign rsp.rdata = sel_ay2 ? ay2_rdata : ay1_rdata;

   ////////////////////////////////
   // Two chips side by side
   ////////////////////////////////

   ay_tone_psg ay1_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .tick    (tick),
      .addr_we (addr_we[0]),
      .data_we (data_we[0]),
      .wdata   (io.wdata),
      .rdata   (ay1_rdata),
      .level   (ay1_level)
   );

   ay_tone_psg ay2_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .tick    (tick),
      .addr_we (addr_we[1]),
      .data_we (data_we[1]),
      .wdata   (io.wdata),
      .rdata   (ay2_rdata),
      .level   (ay2_level)
   );

   a_one_chip_written : assert property (@(posedge clk) disable iff (!rst_n)
      !((ay1_i.addr_we || ay1_i.data_we) && (ay2_i.addr_we || ay2_i.data_we)));

endmodule

//--- verilog/zx_audio_pkg.sv
package zx_audio_pkg;

   ////////////////////////////////
   // Bus types
   ////////////////////////////////

   // One CPU bus sample, Z80 style strobes
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
   } io_req_t;

   // Device reply, oe_n low marks rdata valid
   typedef struct packed {
      logic [7:0] rdata;
      logic       oe_n;
   } io_rsp_t;

   ////////////////////////////////
   // Audio types
   ////////////////////////////////

   // Sum of three 4-bit channel volumes, 0 to 45
   typedef logic [5:0] psg_level_t;

   // Port 0xFE outputs plus the ear pin
   typedef struct packed {
      logic spk;
      logic mic;
      logic ear;
   } beeper_t;

   ////////////////////////////////
   // Port map
   ////////////////////////////////

   localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;
   localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;
   localparam logic [7:0]  ULA_PORT_LSB    = 8'hFE;

   // ZX-Uno register numbers
   localparam logic [7:0]  REG_AUDIO_CTRL  = 8'hF7;

   // Chip select codes on the AY address port
   localparam logic [7:0]  AY_SEL_1        = 8'hFF;
   localparam logic [7:0]  AY_SEL_2        = 8'hFE;

endpackage

//--- verilog/zx_audio_top.sv
`timescale 1ns/1ps

module zx_audio_top #(
   parameter int PSG_DIV    = 8,
   parameter int DAC_BITS   = 10,
   parameter int BEEP_LEVEL = 256
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  zx_audio_pkg::io_req_t io,
   input  logic                  ear,
   output logic [7:0]            rdata,
   output logic                  bus_oe_n,
   output logic                  audio_out
);

   zx_audio_pkg::io_rsp_t    regs_rsp;
   zx_audio_pkg::io_rsp_t    ts_rsp;
   zx_audio_pkg::psg_level_t ay1_level;
   zx_audio_pkg::psg_level_t ay2_level;
   zx_audio_pkg::beeper_t    beep;
   logic [1:0]               ay_gain;
   logic                     ay2_mute;

   ////////////////////////////////
   // Ports and sound sources
   ////////////////////////////////

   // Register number stays local, the AY side has its own ports
   io_port_regs regs_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .io         (io),
      .ear        (ear),
      .rsp        (regs_rsp),
      .zxuno_addr (),
      .ay_gain    (ay_gain),
      .ay2_mute   (ay2_mute),
      .beep       (beep)
   );

   turbosound #(
      .PSG_DIV (PSG_DIV)
   ) turbosound_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .io        (io),
      .rsp       (ts_rsp),
      .ay1_level (ay1_level),
      .ay2_level (ay2_level)
   );

   audio_mixer #(
      .DAC_BITS   (DAC_BITS),
      .BEEP_LEVEL (BEEP_LEVEL)
   ) mixer_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ay1_level (ay1_level),
      .ay2_level (ay2_level),
      .ay_gain   (ay_gain),
      .ay2_mute  (ay2_mute),
      .beep      (beep),
      .audio_out (audio_out)
   );

   // AY first, then ZX-Uno and ULA ports, else idle bus
   assign rdata = !ts_rsp.oe_n   ? ts_rsp.rdata   :
                  !regs_rsp.oe_n ? regs_rsp.rdata :
                                   8'hFF;

   assign bus_oe_n = ts_rsp.oe_n & regs_rsp.oe_n;

endmodule
